// ==== Makefile ====
SRCS := $(wildcard common/*.sv rtl/*.sv modulation/*.sv dv/*.sv)

all: run

obj_dir/Vtb_mem_hub: build.f $(SRCS)
	verilator --binary -j 0 --timescale 1ns/1ns --top-module tb_mem_hub -f build.f

run: obj_dir/Vtb_mem_hub
	./obj_dir/Vtb_mem_hub | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== build.f ====
common/mem_hub_pkg.sv
rtl/apb_mem_ctl.sv
rtl/ctl_regfile.sv
modulation/mod_seg_mem.sv
rtl/duty_table_mem.sv
rtl/mem_hub_top.sv
dv/mem_hub_checker.sv
dv/tb_mem_hub.sv

// ==== common/mem_hub_pkg.sv ====
`default_nettype none

package mem_hub_pkg;

  // Data and address widths
  typedef logic [15:0] word_t;
  typedef logic [15:0] apb_addr_t;
  typedef logic [7:0]  ctl_addr_t;
  typedef logic [9:0]  mod_addr_t;
  typedef logic [10:0] duty_addr_t;
  typedef logic [7:0]  duty_t;

  // Memory depths
  localparam int MOD_DEPTH       = 1024;
  localparam int DUTY_PAGE_DEPTH = 1024;

  // Memory select, taken from paddr[15:14]
  localparam logic [1:0] SEL_CTL  = 2'd0;
  localparam logic [1:0] SEL_MOD  = 2'd1;
  localparam logic [1:0] SEL_DUTY = 2'd2;

  // Controller sub-block, taken from paddr[13:8]
  localparam logic [5:0] CTL_SEL_MAIN = 6'd0;

  // Register indices with side effects on the selectors
  localparam ctl_addr_t ADDR_MOD_WR_SEGMENT = 8'h20;
  localparam ctl_addr_t ADDR_DUTY_WR_PAGE   = 8'h21;

  // APB slave states
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } apb_state_t;

endpackage

`default_nettype wire

// ==== dv/mem_hub_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hub_checker
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              rst_n,
  input  wire [2:0]        test_id,
  input  wire              xfer_done,
  input  wire              xfer_write,
  input  wire apb_addr_t   xfer_addr,
  input  wire word_t       xfer_wdata,
  input  wire word_t       xfer_rdata,
  input  wire              xfer_slverr,
  input  wire [3:0]        xfer_cycles,
  input  wire              pready,
  input  wire              pslverr,
  input  wire ctl_addr_t   ctl_raddr,
  input  wire word_t       ctl_rdata,
  input  wire mod_addr_t   mod_idx,
  input  wire              mod_segment,
  input  wire word_t       mod_value,
  input  wire duty_addr_t  duty_idx,
  input  wire duty_t       duty_value,
  output int               error_count,
  output int               check_count
);

  // Reference model of the three memories and the selectors
  word_t regs [256];
  word_t mod_mem [2][MOD_DEPTH];
  logic  mod_ok [2][MOD_DEPTH];
  duty_t duty_mem [2*DUTY_PAGE_DEPTH];
  logic  duty_ok [2*DUTY_PAGE_DEPTH];
  logic  mod_wseg;
  logic  duty_wpage;
  bit    rst_seen;
  // Core read expectations, one cycle behind the index
  word_t exp_ctl;
  word_t exp_mod;
  duty_t exp_duty;
  logic  ctl_pend;
  logic  mod_pend;
  logic  duty_pend;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "reset";
      3'd1: return "register_bank";
      3'd2: return "mod_double_buffer";
      3'd3: return "duty_pages";
      default: return "error_response";
    endcase
  endfunction

  task automatic check_value(input string what, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name(test_id), what, exp, act);
    end
  endtask

  // Completed transfer against the address map
  task automatic apply_xfer();
    logic [1:0] sel;
    ctl_addr_t  a8;
    logic       mapped;
    sel = xfer_addr[15:14];
    a8  = xfer_addr[7:0];
    mapped = ((sel == SEL_CTL) && (xfer_addr[13:8] == CTL_SEL_MAIN)) ||
             (xfer_write && ((sel == SEL_MOD) || (sel == SEL_DUTY)));
    check_value("transfer cycles", 16'd3, word_t'(xfer_cycles));
    check_value("pslverr", word_t'(!mapped), word_t'(xfer_slverr));
    if (mapped && !xfer_write) begin
      check_value("APB register read", regs[a8], xfer_rdata);
    end
    if (mapped && xfer_write) begin
      case (sel)
        SEL_CTL: begin
          regs[a8] = xfer_wdata;
          if (a8 == ADDR_MOD_WR_SEGMENT) begin
            mod_wseg = xfer_wdata[0];
          end
          if (a8 == ADDR_DUTY_WR_PAGE) begin
            duty_wpage = xfer_wdata[0];
          end
        end
        SEL_MOD: begin
          mod_mem[mod_wseg][xfer_addr[9:0]] = xfer_wdata;
          mod_ok[mod_wseg][xfer_addr[9:0]]  = 1'b1;
        end
        default: begin
          duty_mem[{duty_wpage, xfer_addr[9:0]}] = xfer_wdata[7:0];
          duty_ok[{duty_wpage, xfer_addr[9:0]}]  = 1'b1;
        end
      endcase
    end
  endtask

  always @(posedge bus_clk) begin
    if (!rst_n) begin
      // Outputs quiet once the first reset edge has passed
      if (rst_seen) begin
        check_value("pready in reset", 16'd0, word_t'(pready));
        check_value("pslverr in reset", 16'd0, word_t'(pslverr));
        check_value("core register read in reset", 16'd0, ctl_rdata);
      end
      rst_seen = 1'b1;
      for (int i = 0; i < 256; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < MOD_DEPTH; i++) begin
        mod_ok[0][i] = 1'b0;
        mod_ok[1][i] = 1'b0;
      end
      for (int i = 0; i < 2*DUTY_PAGE_DEPTH; i++) begin
        duty_ok[i] = 1'b0;
      end
      mod_wseg   = 1'b0;
      duty_wpage = 1'b0;
      ctl_pend   = 1'b0;
      mod_pend   = 1'b0;
      duty_pend  = 1'b0;
    end else begin
      if (ctl_pend) begin
        check_value("core register read", exp_ctl, ctl_rdata);
      end
      if (mod_pend) begin
        check_value("core modulation read", exp_mod, mod_value);
      end
      if (duty_pend) begin
        check_value("core duty read", word_t'(exp_duty), word_t'(duty_value));
      end
      // Write committed at the previous edge becomes visible to reads now
      if (xfer_done) begin
        apply_xfer();
      end
      exp_ctl   = regs[ctl_raddr];
      ctl_pend  = 1'b1;
      exp_mod   = mod_mem[mod_segment][mod_idx];
      mod_pend  = mod_ok[mod_segment][mod_idx];
      exp_duty  = duty_mem[duty_idx];
      duty_pend = duty_ok[duty_idx];
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_mem_hub.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_hub
  import mem_hub_pkg::*;
();

  localparam logic [31:0] SEED = 32'hba9c_6c65;
  localparam int RESET_CYCLES = 10;
  // Three-cycle transfer plus the cycle that mirrors it to the checker
  localparam int XFER_CYCLES = 4;
  localparam int N_XFERS = 4 + 64 + 50 + 50 + 32;
  localparam int N_CORE = 8 + 32 + 48 + 48;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_XFERS * XFER_CYCLES + N_CORE + 200;
  localparam logic [2:0] T_RESET = 3'd0;
  localparam logic [2:0] T_REG = 3'd1;
  localparam logic [2:0] T_MOD = 3'd2;
  localparam logic [2:0] T_DUTY = 3'd3;
  localparam logic [2:0] T_ERR = 3'd4;

  logic       bus_clk = 1'b0;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       pslverr;
  ctl_addr_t  ctl_raddr;
  word_t      ctl_rdata;
  mod_addr_t  mod_idx;
  logic       mod_segment;
  word_t      mod_value;
  duty_addr_t duty_idx;
  duty_t      duty_value;
  logic [2:0] test_id;
  logic       xfer_done;
  logic       xfer_write;
  apb_addr_t  xfer_addr;
  word_t      xfer_wdata;
  word_t      xfer_rdata;
  logic       xfer_slverr;
  logic [3:0] xfer_cycles;
  int         error_count;
  int         check_count;
  int         cycle_cnt;
  ctl_addr_t  reg_used[$];
  logic [9:0] mod_used[$];
  logic [9:0] duty_used[$];

  always #20 bus_clk = ~bus_clk;

  mem_hub_top DUT (
    .bus_clk(bus_clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ctl_raddr(ctl_raddr), .ctl_rdata(ctl_rdata), .mod_idx(mod_idx),
    .mod_segment(mod_segment), .mod_value(mod_value), .duty_idx(duty_idx),
    .duty_value(duty_value)
  );

  mem_hub_checker u_checker (
    .bus_clk(bus_clk), .rst_n(rst_n), .test_id(test_id), .xfer_done(xfer_done),
    .xfer_write(xfer_write), .xfer_addr(xfer_addr), .xfer_wdata(xfer_wdata),
    .xfer_rdata(xfer_rdata), .xfer_slverr(xfer_slverr), .xfer_cycles(xfer_cycles),
    .pready(pready), .pslverr(pslverr), .ctl_raddr(ctl_raddr), .ctl_rdata(ctl_rdata),
    .mod_idx(mod_idx), .mod_segment(mod_segment), .mod_value(mod_value),
    .duty_idx(duty_idx), .duty_value(duty_value), .error_count(error_count),
    .check_count(check_count)
  );

  task automatic tick();
    @(posedge bus_clk);
    xfer_done <= 1'b0;
  endtask

  task automatic start_test(input logic [2:0] id);
    tick();
    test_id <= id;
  endtask

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t data);
    int cycles;
    tick();
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    cycles = 1;
    @(posedge bus_clk);
    penable <= 1'b1;
    // pready as it stood before the edge
    do begin
      @(posedge bus_clk);
      cycles++;
    end while (!pready);
    psel        <= 1'b0;
    penable     <= 1'b0;
    xfer_done   <= 1'b1;
    xfer_write  <= wr;
    xfer_addr   <= addr;
    xfer_wdata  <= data;
    xfer_rdata  <= prdata;
    xfer_slverr <= pslverr;
    xfer_cycles <= 4'(cycles);
  endtask

  // Core indices aim at written words where there are any
  task automatic core_reads(input int n);
    for (int i = 0; i < n; i++) begin
      tick();
      ctl_raddr   <= 8'($urandom);
      mod_segment <= 1'($urandom);
      if (mod_used.size() > 0) begin
        mod_idx <= mod_used[$urandom % mod_used.size()];
      end
      if (duty_used.size() > 0) begin
        duty_idx <= {1'($urandom), duty_used[$urandom % duty_used.size()]};
      end
    end
  endtask

  initial begin
    logic [9:0] idx;
    logic       wr;
    ctl_addr_t  a8;
    void'($urandom(SEED));
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    ctl_raddr = '0;
    mod_idx = '0;
    mod_segment = 1'b0;
    duty_idx = '0;
    test_id = T_RESET;
    xfer_done = 1'b0;
    xfer_write = 1'b0;
    xfer_addr = '0;
    xfer_wdata = '0;
    xfer_rdata = '0;
    xfer_slverr = 1'b0;
    xfer_cycles = '0;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b0, {8'h00, 8'($urandom)}, '0);
    end
    core_reads(8);

    start_test(T_REG);
    for (int i = 0; i < 32; i++) begin
      a8 = 8'($urandom);
      reg_used.push_back(a8);
      apb_xfer(1'b1, {8'h00, a8}, 16'($urandom));
    end
    for (int i = 0; i < 32; i++) begin
      a8 = i[0] ? 8'($urandom) : reg_used[$urandom % reg_used.size()];
      apb_xfer(1'b0, {8'h00, a8}, '0);
    end
    core_reads(32);

    // Fill segment 0, then the same indices in segment 1
    start_test(T_MOD);
    apb_xfer(1'b1, {8'h00, ADDR_MOD_WR_SEGMENT}, 16'h0000);
    for (int i = 0; i < 24; i++) begin
      idx = 10'($urandom);
      mod_used.push_back(idx);
      apb_xfer(1'b1, {SEL_MOD, 4'($urandom), idx}, 16'($urandom));
    end
    apb_xfer(1'b1, {8'h00, ADDR_MOD_WR_SEGMENT}, 16'h0001);
    for (int i = 0; i < 24; i++) begin
      apb_xfer(1'b1, {SEL_MOD, 4'($urandom), mod_used[i]}, 16'($urandom));
    end
    core_reads(48);

    start_test(T_DUTY);
    apb_xfer(1'b1, {8'h00, ADDR_DUTY_WR_PAGE}, 16'h0000);
    for (int i = 0; i < 24; i++) begin
      idx = 10'($urandom);
      duty_used.push_back(idx);
      apb_xfer(1'b1, {SEL_DUTY, 4'($urandom), idx}, 16'($urandom));
    end
    apb_xfer(1'b1, {8'h00, ADDR_DUTY_WR_PAGE}, 16'h0001);
    for (int i = 0; i < 24; i++) begin
      apb_xfer(1'b1, {SEL_DUTY, 4'($urandom), duty_used[i]}, 16'($urandom));
    end
    core_reads(48);

    // Rejected accesses, then read back the register bank
    start_test(T_ERR);
    for (int i = 0; i < 16; i++) begin
      a8 = 8'($urandom);
      wr = 1'($urandom);
      reg_used.push_back(a8);
      case (i % 4)
        0: apb_xfer(1'b0, {SEL_MOD, 4'($urandom), 10'($urandom)}, '0);
        1: apb_xfer(1'b0, {SEL_DUTY, 4'($urandom), 10'($urandom)}, '0);
        2: apb_xfer(wr, {2'd3, 6'($urandom), a8}, 16'($urandom));
        default: apb_xfer(wr, {2'd0, 6'(($urandom % 63) + 1), a8}, 16'($urandom));
      endcase
    end
    for (int i = 0; i < 16; i++) begin
      apb_xfer(1'b0, {8'h00, reg_used[$urandom % reg_used.size()]}, '0);
    end

    repeat (4) tick();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== modulation/mod_seg_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module mod_seg_mem
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              mod_we,
  input  wire              mod_wr_segment,
  input  wire apb_addr_t   wr_addr,
  input  wire word_t       wr_data,
  input  wire mod_addr_t   mod_idx,
  input  wire              mod_segment,
  output word_t            mod_value
);

  word_t     seg0 [MOD_DEPTH];
  word_t     seg1 [MOD_DEPTH];
  mod_addr_t wr_idx;
  word_t     rd0;
  word_t     rd1;
  logic      rd_seg;

  assign wr_idx = wr_addr[9:0];

  // Host fills whichever segment is selected for writing
  always_ff @(posedge bus_clk) begin
    if (mod_we && !mod_wr_segment) begin
      seg0[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (mod_we && mod_wr_segment) begin
      seg1[wr_idx] <= wr_data;
    end
  end

  // Both segments read every cycle
  always_ff @(posedge bus_clk) begin
    rd0 <= seg0[mod_idx];
    rd1 <= seg1[mod_idx];
  end

  // Segment choice follows the data through the read register
  always_ff @(posedge bus_clk) begin
    rd_seg <= mod_segment;
  end

  assign mod_value = rd_seg ? rd1 : rd0;

endmodule

`default_nettype wire

// ==== rtl/apb_mem_ctl.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_mem_ctl
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              rst_n,
  input  wire              psel,
  input  wire              penable,
  input  wire              pwrite,
  input  wire apb_addr_t   paddr,
  input  wire word_t       pwdata,
  output word_t            prdata,
  output logic             pready,
  output logic             pslverr,
  input  wire word_t       host_rdata,
  output logic             ctl_we,
  output logic             mod_we,
  output logic             duty_we,
  output apb_addr_t        wr_addr,
  output word_t            wr_data,
  output logic             mod_wr_segment,
  output logic             duty_wr_page
);

  apb_state_t state;
  logic [1:0] sel;
  logic [5:0] sub;
  logic       dec_err;
  logic       is_wr;
  logic       err_q;
  logic [1:0] tgt_q;

  assign sel = paddr[15:14];
  assign sub = paddr[13:8];

  // Unmapped select, foreign controller sub-block, or a read of a write-only memory
  assign dec_err = (sel == 2'd3) ||
                   ((sel == SEL_CTL) && (sub != CTL_SEL_MAIN)) ||
                   (!pwrite && (sel != SEL_CTL));

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      state          <= IDLE;
      is_wr          <= 1'b0;
      err_q          <= 1'b0;
      tgt_q          <= SEL_CTL;
      mod_wr_segment <= 1'b0;
      duty_wr_page   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (psel && !penable) begin
            state <= ACCESS;
            is_wr <= pwrite;
            err_q <= dec_err;
            tgt_q <= sel;
          end
        end
        // One wait state before completion
        ACCESS: begin
          if (psel && penable) begin
            state <= DONE;
          end
        end
        DONE: begin
          state <= IDLE;
          if (ctl_we && (wr_addr[7:0] == ADDR_MOD_WR_SEGMENT)) begin
            mod_wr_segment <= wr_data[0];
          end
          if (ctl_we && (wr_addr[7:0] == ADDR_DUTY_WR_PAGE)) begin
            duty_wr_page <= wr_data[0];
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data held for the whole transfer
  always_ff @(posedge bus_clk) begin
    if ((state == IDLE) && psel && !penable) begin
      wr_addr <= paddr;
      wr_data <= pwdata;
    end
  end

  assign pready  = (state == DONE);
  assign pslverr = pready && err_q;
  assign prdata  = (pready && !is_wr && !err_q) ? host_rdata : '0;

  // Strobes fire in the completion cycle only
  assign ctl_we  = pready && is_wr && !err_q && (tgt_q == SEL_CTL);
  assign mod_we  = pready && is_wr && !err_q && (tgt_q == SEL_MOD);
  assign duty_we = pready && is_wr && !err_q && (tgt_q == SEL_DUTY);

endmodule

`default_nettype wire

// ==== rtl/ctl_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctl_regfile
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              rst_n,
  input  wire              ctl_we,
  input  wire apb_addr_t   wr_addr,
  input  wire word_t       wr_data,
  output word_t            host_rdata,
  input  wire ctl_addr_t   ctl_raddr,
  output word_t            ctl_rdata
);

  localparam int CTL_DEPTH = 256;

  word_t     regs [CTL_DEPTH];
  ctl_addr_t host_idx;

  assign host_idx = wr_addr[7:0];

  // Whole bank clears on reset
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < CTL_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl_we) begin
      regs[host_idx] <= wr_data;
    end
  end

  // Registered read ports, host and core
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      host_rdata <= '0;
      ctl_rdata  <= '0;
    end else begin
      host_rdata <= regs[host_idx];
      ctl_rdata  <= regs[ctl_raddr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/duty_table_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module duty_table_mem
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              duty_we,
  input  wire              duty_wr_page,
  input  wire apb_addr_t   wr_addr,
  input  wire word_t       wr_data,
  input  wire duty_addr_t  duty_idx,
  output duty_t            duty_value
);

  localparam int DUTY_DEPTH = 2 * DUTY_PAGE_DEPTH;

  duty_t      table_mem [DUTY_DEPTH];
  duty_addr_t wr_idx;

  // Page bit on top of the in-page index
  assign wr_idx = {duty_wr_page, wr_addr[9:0]};

  // Only the low byte of the APB word is an entry
  always_ff @(posedge bus_clk) begin
    if (duty_we) begin
      table_mem[wr_idx] <= wr_data[7:0];
    end
  end

  always_ff @(posedge bus_clk) begin
    duty_value <= table_mem[duty_idx];
  end

endmodule

`default_nettype wire

// ==== rtl/mem_hub_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_hub_top
  import mem_hub_pkg::*;
(
  input  wire              bus_clk,
  input  wire              rst_n,
  // APB slave
  input  wire              psel,
  input  wire              penable,
  input  wire              pwrite,
  input  wire apb_addr_t   paddr,
  input  wire word_t       pwdata,
  output word_t            prdata,
  output logic             pready,
  output logic             pslverr,
  // Core read ports
  input  wire ctl_addr_t   ctl_raddr,
  output word_t            ctl_rdata,
  input  wire mod_addr_t   mod_idx,
  input  wire              mod_segment,
  output word_t            mod_value,
  input  wire duty_addr_t  duty_idx,
  output duty_t            duty_value
);

  word_t     host_rdata;
  logic      ctl_we;
  logic      mod_we;
  logic      duty_we;
  apb_addr_t wr_addr;
  word_t     wr_data;
  logic      mod_wr_segment;
  logic      duty_wr_page;

  apb_mem_ctl u_ctl (
    .bus_clk        (bus_clk),
    .rst_n          (rst_n),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .host_rdata     (host_rdata),
    .ctl_we         (ctl_we),
    .mod_we         (mod_we),
    .duty_we        (duty_we),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .mod_wr_segment (mod_wr_segment),
    .duty_wr_page   (duty_wr_page)
  );

  ctl_regfile u_regfile (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .ctl_we     (ctl_we),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .host_rdata (host_rdata),
    .ctl_raddr  (ctl_raddr),
    .ctl_rdata  (ctl_rdata)
  );

  mod_seg_mem u_mod (
    .bus_clk        (bus_clk),
    .mod_we         (mod_we),
    .mod_wr_segment (mod_wr_segment),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .mod_idx        (mod_idx),
    .mod_segment    (mod_segment),
    .mod_value      (mod_value)
  );

  duty_table_mem u_duty (
    .bus_clk      (bus_clk),
    .duty_we      (duty_we),
    .duty_wr_page (duty_wr_page),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .duty_idx     (duty_idx),
    .duty_value   (duty_value)
  );

endmodule

`default_nettype wire
